//--- list.f
corePkg.sv
decExeIf.sv
regFile.sv
ctrlDecode.sv
aluCore.sv
decodeStage.sv
executeStage.sv
resultStage.sv
coreTop.sv
coreTb.sv

//--- run.sh
#!/bin/sh
# builds and runs the core testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module coreTb -o coreSim
status=$?
if [ $status -ne 0 ]; then
	echo "build failed with status $status"
	exit 1
fi

out=$(./obj_dir/coreSim 2>&1)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -qx "PASS: all tests"; then
	exit 0
fi
exit 1

//--- coreTb.sv
`timescale 1ns/10ps
`default_nettype none

module coreTb import corePkg::*; ();

	typedef struct packed {
		logic en;
		regAddrT r;
		dataT d;
		flagsT f;
	} expT;

	localparam int CLK_NS = 8;
	// reset, then the slots of each test in order.
	localparam int TEST_SLOTS = 2 + 6 + 13 + 11 + 14 + 8 + 62;
	localparam int MARGIN_SLOTS = 20;
	localparam instrT NOP = 24'h600000; // opcode 011.

	logic clk, rstN, flush, wbEn;
	instrT instr;
	regAddrT wbReg;
	dataT wbData;
	flagsT flags;

	dataT modelRegs [NUM_REGS];
	flagsT modelFlags;
	expT expQ [$];
	string nameQ [$];
	string testName;
	integer seed;

	coreTop dut0 (.clk(clk), .rstN(rstN), .instr(instr), .flush(flush), .wbEn(wbEn),
		.wbReg(wbReg), .wbData(wbData), .flags(flags));

	initial begin
		clk = 1'b0;
		forever #(CLK_NS / 2) clk = ~clk;
	end

	initial begin
		#((TEST_SLOTS + MARGIN_SLOTS) * CLK_NS);
		reportFail("watchdog timeout: the tests did not finish in time");
	end

	task automatic reportFail(input string line);
		$display("%s", line);
		$display("FAIL: see errors above");
		$fatal(1);
	endtask

	function automatic dataT refAlu(input aluFunctE fn, input dataT a, input dataT b,
		output flagsT f);
		longint sa, sb, ss, lim;
		dataT y;
		logic c, v;
		c = 1'b0;
		v = 1'b0;
		sa = longint'($signed(a));
		sb = longint'($signed(b));
		lim = longint'(1) <<< (DATA_W - 1); // signed range is -lim to lim-1.
		case (fn)
			FN_ADD: begin
				y = a + b;
				c = ((longint'(a) + longint'(b)) >> DATA_W) != 0;
				ss = sa + sb;
				v = (ss >= lim) || (ss < -lim);
			end
			FN_SUB: begin
				y = a - b;
				c = (a >= b); // no borrow.
				ss = sa - sb;
				v = (ss >= lim) || (ss < -lim);
			end
			FN_AND: y = a & b;
			FN_OR: y = a | b;
			FN_XOR: y = a ^ b;
			FN_SHL: y = a << b[3:0];
			FN_SHR: y = a >> b[3:0];
			default: y = b;
		endcase
		f = {y[DATA_W-1], (y == '0), c, v};
		return y;
	endfunction

	function automatic instrT encReg(input aluFunctE fn, input logic s, input regAddrT rd,
		input regAddrT rs, input regAddrT rt);
		instrT w;
		w = '0;
		w[S_BIT] = s;
		w[RD_LSB +: 4] = rd;
		w[RS_LSB +: 4] = rs;
		w[RT_LSB +: 4] = rt;
		w[FUNCT_LSB +: 3] = fn;
		return w;
	endfunction

	function automatic instrT encImm(input aluFunctE fn, input logic s, input regAddrT rd,
		input regAddrT rs, input logic [7:0] imm);
		instrT w;
		w = '0;
		w[OPCODE_LSB +: 3] = 3'b001;
		w[S_BIT] = s;
		w[RD_LSB +: 4] = rd;
		w[RS_LSB +: 4] = rs;
		w[IMM8_LSB +: 8] = imm;
		w[FUNCT_LSB +: 3] = fn;
		return w;
	endfunction

	function automatic instrT encMove(input regAddrT rd, input logic [15:0] imm);
		instrT w;
		w = '0;
		w[OPCODE_LSB +: 3] = 3'b010;
		w[RD_LSB +: 4] = rd;
		w[15:0] = imm;
		return w;
	endfunction

	// updates the model and returns what the word should produce.
	task automatic predict(input instrT w, input logic fl, output expT e);
		logic [2:0] opc;
		regAddrT rd, rs, rt;
		dataT a, b, y;
		flagsT f;
		opc = w[OPCODE_LSB +: 3];
		rd = w[RD_LSB +: 4];
		rs = w[RS_LSB +: 4];
		rt = w[RT_LSB +: 4];
		e = '0;
		e.r = rd;
		if (!fl && opc == 3'b010) begin
			y = {{8{w[15]}}, w[15:0]};
			e.en = 1'b1;
			e.d = y;
			modelRegs[rd] = y;
		end else if (!fl && (opc == 3'b000 || opc == 3'b001)) begin
			a = modelRegs[rs];
			b = (opc == 3'b000) ? modelRegs[rt] : {16'b0, w[IMM8_LSB +: 8]};
			y = refAlu(aluFunctE'(w[FUNCT_LSB +: 3]), a, b, f);
			e.en = 1'b1;
			e.d = y;
			modelRegs[rd] = y;
			if (w[S_BIT]) modelFlags = f;
		end
		e.f = modelFlags;
	endtask

	task automatic compareOldest();
		expT e;
		string n;
		e = expQ.pop_front();
		n = nameQ.pop_front();
		assert (wbEn === e.en) else reportFail($sformatf(
			"[ERROR] %s: wbEn expected %0b, actual %0b", n, e.en, wbEn));
		if (e.en) begin
			assert (wbReg === e.r) else reportFail($sformatf(
				"[ERROR] %s: wbReg expected %0d, actual %0d", n, e.r, wbReg));
			assert (wbData === e.d) else reportFail($sformatf(
				"[ERROR] %s: wbData expected %06h, actual %06h", n, e.d, wbData));
		end
		assert (flags === e.f) else reportFail($sformatf(
			"[ERROR] %s: flags expected %04b, actual %04b", n, e.f, flags));
	endtask

	// one slot: check the word from two edges back, then present the next.
	task automatic issue(input instrT w, input logic fl);
		expT e;
		@(posedge clk);
		#1;
		if (expQ.size() == 2) compareOldest();
		instr = w;
		flush = fl;
		predict(w, fl, e);
		expQ.push_back(e);
		nameQ.push_back(testName);
	endtask

	task automatic drain();
		repeat (2) issue(NOP, 1'b0);
	endtask

	task automatic resetState();
		testName = "resetState";
		assert (wbEn === 1'b0 && flags === 4'h0 && wbData === '0) else reportFail($sformatf(
			"[ERROR] resetState: wbEn/flags/wbData expected 0/0/0, actual %0b/%0h/%06h",
			wbEn, flags, wbData));
		repeat (6) issue(NOP, 1'b0);
	endtask

	task automatic moveAndRegisterOps();
		testName = "moveAndRegisterOps";
		issue(encMove(4'd1, 16'h1234), 1'b0);
		issue(encMove(4'd2, 16'hF0F0), 1'b0); // negative, sign-extends.
		issue(encMove(4'd3, 16'h0005), 1'b0); // shift amount.
		for (int i = 0; i < 8; i++) begin
			issue(encReg(aluFunctE'(3'(i)), i[0], regAddrT'(4 + i), 4'd1,
				(i == 5 || i == 6) ? 4'd3 : 4'd2), 1'b0);
		end
		drain();
	endtask

	task automatic dependentChain();
		testName = "dependentChain";
		issue(encMove(4'd1, 16'h0003), 1'b0);
		issue(encReg(FN_ADD, 1'b0, 4'd2, 4'd1, 4'd1), 1'b0);
		issue(encReg(FN_SHL, 1'b0, 4'd3, 4'd2, 4'd1), 1'b0); // r1 via bypass.
		issue(encReg(FN_SUB, 1'b1, 4'd4, 4'd3, 4'd2), 1'b0);
		issue(encReg(FN_XOR, 1'b0, 4'd4, 4'd4, 4'd3), 1'b0);
		issue(encImm(FN_ADD, 1'b0, 4'd4, 4'd4, 8'h7F), 1'b0);
		issue(encReg(FN_OR, 1'b0, 4'd5, 4'd4, 4'd4), 1'b0);
		issue(NOP, 1'b0);
		issue(encReg(FN_ADD, 1'b1, 4'd6, 4'd5, 4'd4), 1'b0); // r5 two back, r4 three.
		drain();
	endtask

	task automatic immediateAndFlags();
		testName = "immediateAndFlags";
		issue(encMove(4'd1, 16'h7FFF), 1'b0);
		issue(encImm(FN_SHL, 1'b0, 4'd1, 4'd1, 8'h08), 1'b0);
		issue(encImm(FN_OR, 1'b0, 4'd1, 4'd1, 8'hFF), 1'b0); // largest positive.
		issue(encImm(FN_ADD, 1'b1, 4'd2, 4'd1, 8'h01), 1'b0); // signed overflow.
		issue(encMove(4'd3, 16'hFFFF), 1'b0);
		issue(encImm(FN_ADD, 1'b1, 4'd4, 4'd3, 8'h01), 1'b0); // carry and zero.
		issue(encImm(FN_ADD, 1'b0, 4'd5, 4'd3, 8'h02), 1'b0);
		issue(encMove(4'd6, 16'h0005), 1'b0);
		issue(encImm(FN_SUB, 1'b1, 4'd7, 4'd6, 8'h09), 1'b0); // negative.
		issue(encImm(FN_SUB, 1'b1, 4'd7, 4'd6, 8'h05), 1'b0);
		issue(encImm(FN_AND, 1'b1, 4'd8, 4'd3, 8'hF0), 1'b0);
		issue(encMove(4'd9, 16'h8000) | (24'h1 << S_BIT), 1'b0); // S ignored.
		drain();
	endtask

	task automatic flushBubble();
		testName = "flushBubble";
		issue(encMove(4'd1, 16'h0111), 1'b0);
		issue(encMove(4'd1, 16'h0222), 1'b1);
		issue(encReg(FN_ADD, 1'b0, 4'd2, 4'd1, 4'd0), 1'b0);
		issue(encReg(FN_SUB, 1'b1, 4'd3, 4'd1, 4'd1), 1'b1); // zero result dropped.
		issue(NOP, 1'b0);
		issue(encReg(FN_OR, 1'b0, 4'd4, 4'd1, 4'd2), 1'b0);
		drain();
	endtask

	task automatic randomProgram();
		instrT w;
		logic fl;
		testName = "randomProgram";
		for (int i = 0; i < 60; i++) begin
			w = instrT'($random(seed));
			fl = (($random(seed) & 7) == 0);
			issue(w, fl);
		end
		drain();
	endtask

	initial begin
		seed = 73886;
		rstN = 1'b0;
		flush = 1'b0;
		instr = NOP;
		modelFlags = '0;
		for (int i = 0; i < NUM_REGS; i++) begin
			modelRegs[i] = '0;
		end
		testName = "reset";
		repeat (2) @(posedge clk);
		#1;
		rstN = 1'b1;
		resetState();
		moveAndRegisterOps();
		dependentChain();
		immediateAndFlags();
		flushBubble();
		randomProgram();
		$display("PASS: all tests");
		$finish;
	end

endmodule

`default_nettype wire

//--- coreTop.sv
`timescale 1ns/10ps
`default_nettype none

module coreTop import corePkg::*; (
	input logic clk,
	input logic rstN,
	input instrT instr,
	input logic flush,
	output logic wbEn,
	output regAddrT wbReg,
	output dataT wbData,
	output flagsT flags
);

	logic resValid, resWriteEn, resIsMove;
	regAddrT resReg;
	dataT resAlu, resImm;

	decExeIf deIf ();

	decodeStage dec0 (.clk(clk), .rstN(rstN), .instr(instr), .flush(flush), .wbEn(wbEn),
		.wbReg(wbReg), .wbData(wbData), .toExe(deIf.producer));

	// write-back also feeds the forwarding muxes.
	executeStage exe0 (.clk(clk), .rstN(rstN), .fromDec(deIf.consumer), .wbEn(wbEn),
		.wbReg(wbReg), .wbData(wbData), .resValid(resValid), .resWriteEn(resWriteEn),
		.resReg(resReg), .resAlu(resAlu), .resImm(resImm), .resIsMove(resIsMove),
		.flags(flags));

	resultStage res0 (.clk(clk), .rstN(rstN), .resValid(resValid), .resWriteEn(resWriteEn),
		.resReg(resReg), .resAlu(resAlu), .resImm(resImm), .resIsMove(resIsMove),
		.wbEn(wbEn), .wbReg(wbReg), .wbData(wbData));

endmodule

`default_nettype wire

//--- resultStage.sv
`timescale 1ns/10ps
`default_nettype none

module resultStage import corePkg::*; (
	input logic clk,
	input logic rstN,
	input logic resValid,
	input logic resWriteEn,
	input regAddrT resReg,
	input dataT resAlu,
	input dataT resImm,
	input logic resIsMove,
	output logic wbEn,
	output regAddrT wbReg,
	output dataT wbData
);

	logic validQ, writeEnQ, isMoveQ;
	dataT aluQ, immQ;

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			validQ <= 1'b0;
			writeEnQ <= 1'b0;
			isMoveQ <= 1'b0;
			wbReg <= '0;
			aluQ <= '0; // wbData reads zero out of reset.
			immQ <= '0;
		end else begin
			validQ <= resValid;
			writeEnQ <= resWriteEn;
			isMoveQ <= resIsMove;
			wbReg <= resReg;
			aluQ <= resAlu;
			immQ <= resImm;
		end
	end

	assign wbEn = validQ && writeEnQ;
	assign wbData = isMoveQ ? immQ : aluQ;

endmodule

`default_nettype wire

//--- executeStage.sv
`timescale 1ns/10ps
`default_nettype none

module executeStage import corePkg::*; (
	input logic clk,
	input logic rstN,
	decExeIf.consumer fromDec,
	input logic wbEn,
	input regAddrT wbReg,
	input dataT wbData,
	output logic resValid,
	output logic resWriteEn,
	output regAddrT resReg,
	output dataT resAlu,
	output dataT resImm,
	output logic resIsMove,
	output flagsT flags
);

	dataT fwdA, fwdB, aluB, aluY;
	flagsT aluFlags;

	// newest result comes from the result register.
	assign fwdA = (wbEn && (wbReg == fromDec.srcA)) ? wbData : fromDec.opA;
	assign fwdB = (wbEn && (wbReg == fromDec.srcB)) ? wbData : fromDec.opB;
	assign aluB = fromDec.useImm ? fromDec.extImm : fwdB;

	aluCore alu0 (.funct(fromDec.aluFunct), .a(fwdA), .b(aluB), .y(aluY), .nzcv(aluFlags));

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			flags <= '0;
		end else if (fromDec.valid && fromDec.setFlags) begin
			flags <= aluFlags;
		end
	end

	// handed to the result register.
	assign resValid = fromDec.valid;
	assign resWriteEn = fromDec.writeEn;
	assign resReg = fromDec.destReg;
	assign resAlu = aluY;
	assign resImm = fromDec.extImm;
	assign resIsMove = fromDec.isMove;

endmodule

`default_nettype wire

//--- decodeStage.sv
`timescale 1ns/10ps
`default_nettype none

module decodeStage import corePkg::*; (
	input logic clk,
	input logic rstN,
	input instrT instr,
	input logic flush,
	input logic wbEn,
	input regAddrT wbReg,
	input dataT wbData,
	decExeIf.producer toExe
);

	opcodeE opcode;
	aluFunctE funct;
	logic sBit;
	regAddrT rd, rs, rt;
	dataT rdA, rdB;
	dataT immZ, immS, extImm;
	logic writeEn, useImm, isMove, setFlags;
	aluFunctE aluFunct;

	assign opcode = opcodeE'(instr[OPCODE_LSB +: 3]);
	assign sBit = instr[S_BIT];
	assign rd = instr[RD_LSB +: REG_W];
	assign rs = instr[RS_LSB +: REG_W];
	assign rt = instr[RT_LSB +: REG_W];
	assign funct = aluFunctE'(instr[FUNCT_LSB +: 3]);

	assign immZ = {16'b0, instr[IMM8_LSB +: 8]};
	assign immS = {{8{instr[15]}}, instr[15:0]}; // move immediate.
	assign extImm = isMove ? immS : immZ;

	ctrlDecode ctrl0 (.opcode(opcode), .funct(funct), .sBit(sBit), .writeEn(writeEn),
		.useImm(useImm), .isMove(isMove), .aluFunct(aluFunct), .setFlags(setFlags));

	regFile rf0 (.clk(clk), .rstN(rstN), .rdAddrA(rs), .rdAddrB(rt), .rdDataA(rdA),
		.rdDataB(rdB), .wrEn(wbEn), .wrAddr(wbReg), .wrData(wbData));

	// decode-to-execute register.
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			toExe.valid <= 1'b0;
			toExe.writeEn <= 1'b0;
			toExe.setFlags <= 1'b0;
			toExe.useImm <= 1'b0;
			toExe.isMove <= 1'b0;
			toExe.aluFunct <= FN_ADD;
			toExe.destReg <= '0;
			toExe.srcA <= '0;
			toExe.srcB <= '0;
			toExe.opA <= '0;
			toExe.opB <= '0;
			toExe.extImm <= '0;
		end else begin
			toExe.valid <= !flush; // flush loads a bubble.
			toExe.writeEn <= writeEn;
			toExe.setFlags <= setFlags;
			toExe.useImm <= useImm;
			toExe.isMove <= isMove;
			toExe.aluFunct <= aluFunct;
			toExe.destReg <= rd;
			toExe.srcA <= rs;
			toExe.srcB <= rt;
			toExe.opA <= rdA;
			toExe.opB <= rdB;
			toExe.extImm <= extImm;
		end
	end

endmodule

`default_nettype wire

//--- aluCore.sv
`timescale 1ns/10ps
`default_nettype none

module aluCore import corePkg::*; (
	input aluFunctE funct,
	input dataT a,
	input dataT b,
	output dataT y,
	output flagsT nzcv
);

	logic [DATA_W:0] addW, subW; // one extra bit for carry.
	logic carry, ovf;

	assign addW = {1'b0, a} + {1'b0, b};
	assign subW = {1'b0, a} + {1'b0, ~b} + (DATA_W+1)'(1); // carry set means no borrow.

	always_comb begin
		carry = 1'b0;
		ovf = 1'b0;
		case (funct)
			FN_ADD: begin
				y = addW[DATA_W-1:0];
				carry = addW[DATA_W];
				ovf = (a[DATA_W-1] == b[DATA_W-1]) && (y[DATA_W-1] != a[DATA_W-1]);
			end
			FN_SUB: begin
				y = subW[DATA_W-1:0];
				carry = subW[DATA_W];
				ovf = (a[DATA_W-1] != b[DATA_W-1]) && (y[DATA_W-1] != a[DATA_W-1]);
			end
			FN_AND: y = a & b;
			FN_OR: y = a | b;
			FN_XOR: y = a ^ b;
			FN_SHL: y = a << b[3:0]; // only the low four bits shift.
			FN_SHR: y = a >> b[3:0];
			default: y = b;
		endcase
	end

	assign nzcv = {y[DATA_W-1], (y == '0), carry, ovf};

endmodule

`default_nettype wire

//--- ctrlDecode.sv
`timescale 1ns/10ps
`default_nettype none

module ctrlDecode import corePkg::*; (
	input opcodeE opcode,
	input aluFunctE funct,
	input logic sBit,
	output logic writeEn,
	output logic useImm,
	output logic isMove,
	output aluFunctE aluFunct,
	output logic setFlags
);

	always_comb begin
		// defaults describe a no-op.
		writeEn = 1'b0;
		useImm = 1'b0;
		isMove = 1'b0;
		aluFunct = FN_ADD;
		setFlags = 1'b0;
		case (opcode)
			OP_ALU_REG: begin
				writeEn = 1'b1;
				aluFunct = funct;
				setFlags = sBit;
			end
			OP_ALU_IMM: begin
				writeEn = 1'b1;
				useImm = 1'b1; // imm8 replaces rt.
				aluFunct = funct;
				setFlags = sBit;
			end
			OP_MOVE: begin
				writeEn = 1'b1;
				isMove = 1'b1; // alu value is unused for moves.
			end
			default: ;
		endcase
	end

endmodule

`default_nettype wire

//--- regFile.sv
`timescale 1ns/10ps
`default_nettype none

module regFile import corePkg::*; (
	input logic clk,
	input logic rstN,
	input regAddrT rdAddrA,
	input regAddrT rdAddrB,
	output dataT rdDataA,
	output dataT rdDataB,
	input logic wrEn,
	input regAddrT wrAddr,
	input dataT wrData
);

	dataT regs [NUM_REGS];

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wrEn) begin
			regs[wrAddr] <= wrData;
		end
	end

	// write-through, so a same-cycle read sees the new value.
	assign rdDataA = (wrEn && (wrAddr == rdAddrA)) ? wrData : regs[rdAddrA];
	assign rdDataB = (wrEn && (wrAddr == rdAddrB)) ? wrData : regs[rdAddrB];

endmodule

`default_nettype wire

//--- decExeIf.sv
`timescale 1ns/10ps
`default_nettype none

interface decExeIf import corePkg::*; ();

	logic valid; // low marks a bubble.
	logic writeEn;
	regAddrT destReg;
	regAddrT srcA; // register numbers kept for forwarding.
	regAddrT srcB;
	dataT opA;
	dataT opB;
	dataT extImm;
	logic useImm;
	logic isMove;
	aluFunctE aluFunct;
	logic setFlags;

	modport producer (output valid, writeEn, destReg, srcA, srcB, opA, opB,
		extImm, useImm, isMove, aluFunct, setFlags);

	modport consumer (input valid, writeEn, destReg, srcA, srcB, opA, opB,
		extImm, useImm, isMove, aluFunct, setFlags);

endinterface

`default_nettype wire

//--- corePkg.sv
`default_nettype none

package corePkg;

	localparam int DATA_W = 24;
	localparam int REG_W = 4;
	localparam int NUM_REGS = 16;

	// instruction field positions.
	localparam int OPCODE_LSB = 21;
	localparam int S_BIT = 20;
	localparam int RD_LSB = 16;
	localparam int RS_LSB = 12;
	localparam int RT_LSB = 8;
	localparam int IMM8_LSB = 4; // zero-extended operand of immediate ops.
	localparam int FUNCT_LSB = 1;

	typedef logic [DATA_W-1:0] dataT;
	typedef logic [REG_W-1:0] regAddrT;
	typedef logic [DATA_W-1:0] instrT;
	typedef logic [3:0] flagsT; // N, Z, C, V from msb down.

	typedef enum logic [2:0] {
		OP_ALU_REG = 3'b000,
		OP_ALU_IMM = 3'b001,
		OP_MOVE = 3'b010,
		OP_NOP3 = 3'b011,
		OP_NOP4 = 3'b100,
		OP_NOP5 = 3'b101,
		OP_NOP6 = 3'b110,
		OP_NOP7 = 3'b111
	} opcodeE;

	typedef enum logic [2:0] {
		FN_ADD = 3'b000,
		FN_SUB = 3'b001,
		FN_AND = 3'b010,
		FN_OR = 3'b011,
		FN_XOR = 3'b100,
		FN_SHL = 3'b101,
		FN_SHR = 3'b110,
		FN_PASSB = 3'b111
	} aluFunctE;

endpackage

`default_nettype wire
